//--- Makefile
TOP = tb_icache
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --assert --top-module $(TOP) -f icache.f -Mdir obj_dir
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG) || ! grep -q "test passed" $(LOG); then \
	  echo "simulation reported a failure"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)

//--- icache.f
src/icache_pkg.sv
src/line_ram.sv
src/icache_tag_store.sv
src/icache_ctrl.sv
src/icache_top.sv
sim/tb_icache.sv

//--- sim/tb_icache.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache;

  localparam int N_RAND = 200;
  // cold fetch, rest of the line, conflict pair, uncached pair, random
  localparam int N_FETCH = 1 + 15 + 2 + 2 + N_RAND;
  // capture, lookup, 16 beats at up to 17 cycles each, re-capture, lookup
  localparam int MISS_CYCLES = 4 + icache_pkg::BEATS * 17;
  localparam int MAX_CYCLES = 2 * (N_FETCH * MISS_CYCLES + 20);

  logic clk;
  logic rst;
  icache_pkg::addr_t preif_raddr_i;
  logic preif_raddr_valid_i;
  icache_pkg::word_t if_rdata_o;
  logic if_rdata_valid_o;
  logic mem_req_o;
  icache_pkg::addr_t mem_addr_o;
  icache_pkg::len_t mem_len_o;
  logic mem_ack_i;
  icache_pkg::word_t mem_data_i;

  // outstanding fetches and expected memory requests, in order
  icache_pkg::addr_t fetch_q[$];
  icache_pkg::addr_t req_addr_q[$];
  icache_pkg::len_t req_len_q[$];

  // tb view of the tag array
  logic model_valid [icache_pkg::LINES];
  icache_pkg::tag_t model_tag [icache_pkg::LINES];

  logic [15:0] ack_lfsr;
  logic [15:0] addr_lfsr;
  int beat;
  logic mem_req_prev;
  logic cmp_req_prev;
  int cycles;
  string test_name;
  int word_checks, req_checks;
  int word_errors, addr_errors, len_errors, other_errors;

  icache_top uut (
    .clk                (clk),
    .rst                (rst),
    .preif_raddr_i      (preif_raddr_i),
    .preif_raddr_valid_i(preif_raddr_valid_i),
    .if_rdata_o         (if_rdata_o),
    .if_rdata_valid_o   (if_rdata_valid_o),
    .mem_req_o          (mem_req_o),
    .mem_addr_o         (mem_addr_o),
    .mem_len_o          (mem_len_o),
    .mem_ack_i          (mem_ack_i),
    .mem_data_i         (mem_data_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // memory contents: address rotated, then scrambled
  function automatic icache_pkg::word_t mem_word(input icache_pkg::addr_t a);
    return {a[20:0], a[31:21]} ^ 32'h5a3c_96e1;
  endfunction

  // fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // n fresh bits from the address lfsr, one step per bit
  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      addr_lfsr = lfsr_step(addr_lfsr);
      r = {r[6:0], addr_lfsr[0]};
    end
    return r;
  endfunction

  task automatic check_word(input icache_pkg::word_t exp, input icache_pkg::word_t act);
    word_checks++;
    if (act !== exp) begin
      word_errors++;
      $display("Error %s: fetch word expected %h, actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_addr(input icache_pkg::addr_t exp, input icache_pkg::addr_t act);
    req_checks++;
    if (act !== exp) begin
      addr_errors++;
      $display("Error %s: memory address expected %h, actual %h", test_name, exp, act);
    end
  endtask

  task automatic check_len(input icache_pkg::len_t exp, input icache_pkg::len_t act);
    if (act !== exp) begin
      len_errors++;
      $display("Error %s: burst length expected %0d, actual %0d", test_name, exp, act);
    end
  endtask

  // hit or miss from the tb tag model, queue what the DUT must do
  task automatic predict(input icache_pkg::addr_t a);
    icache_pkg::index_t idx;
    icache_pkg::tag_t tag;
    idx = a[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
    tag = a[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
    fetch_q.push_back(a);
    if (a[31:28] == icache_pkg::UNCACHED_NIBBLE) begin
      // single beat, never allocated
      req_addr_q.push_back({a[31:2], 2'b00});
      req_len_q.push_back(icache_pkg::len_t'(0));
    end else if (!model_valid[idx] || model_tag[idx] != tag) begin
      req_addr_q.push_back({a[31:icache_pkg::OFFSET_W], {icache_pkg::OFFSET_W{1'b0}}});
      req_len_q.push_back(icache_pkg::len_t'(icache_pkg::BEATS - 1));
      model_valid[idx] = 1'b1;
      model_tag[idx] = tag;
    end
  endtask

  // present one request and hold it until the word comes back
  task automatic fetch(input icache_pkg::addr_t a);
    predict(a);
    preif_raddr_i = a;
    preif_raddr_valid_i = 1'b1;
    do begin
      @(negedge clk);
    end while (!if_rdata_valid_o);
  endtask

  task automatic idle_cycles(input int n);
    preif_raddr_valid_i = 1'b0;
    repeat (n) @(negedge clk);
  endtask

  task automatic random_fetches(input int n);
    logic [7:0] sel, t, i, w;
    icache_pkg::addr_t a;
    for (int k = 0; k < n; k++) begin
      sel = rand_bits(3);
      if (sel == 8'd0) begin
        w = rand_bits(6);
        a = {4'h1, 20'h0, w[5:0], 2'b00};
      end else begin
        // 4 tags over 8 indexes, so conflicts are frequent
        t = rand_bits(2);
        i = rand_bits(3);
        w = rand_bits(4);
        a = {4'h2, 13'h0, t[1:0], 4'h0, i[2:0], w[3:0], 2'b00};
      end
      fetch(a);
    end
  endtask

  // memory model, ack drawn from the lfsr every cycle of a request
  initial begin
    mem_ack_i = 1'b0;
    mem_data_i = '0;
    ack_lfsr = 16'd7;
    beat = 0;
    mem_req_prev = 1'b0;
    forever begin
      @(negedge clk);
      // a beat was taken at the last rising edge if req and ack were high
      if (mem_req_o && !mem_req_prev) begin
        beat = 0;
      end else if (mem_req_prev && mem_ack_i) begin
        beat = beat + 1;
      end
      if (mem_req_o) begin
        ack_lfsr = lfsr_step(ack_lfsr);
        mem_ack_i = ack_lfsr[0];
        mem_data_i = mem_word(mem_addr_o + 4 * beat);
      end else begin
        mem_ack_i = 1'b0;
      end
      mem_req_prev = mem_req_o;
    end
  end

  // compare outputs at the falling edge
  initial begin
    cmp_req_prev = 1'b0;
    forever begin
      @(negedge clk);
      if (if_rdata_valid_o) begin
        if (fetch_q.size() == 0) begin
          other_errors++;
          $display("%s: fetch word %h returned with no fetch outstanding", test_name, if_rdata_o);
        end else begin
          check_word(mem_word(fetch_q.pop_front()), if_rdata_o);
        end
      end
      // new request rises
      if (mem_req_o && !cmp_req_prev) begin
        if (req_addr_q.size() == 0) begin
          other_errors++;
          $display("%s: memory request to %h where a hit was predicted", test_name, mem_addr_o);
        end else begin
          check_addr(req_addr_q.pop_front(), mem_addr_o);
          check_len(req_len_q.pop_front(), mem_len_o);
        end
      end
      cmp_req_prev = mem_req_o;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: tests still running after %0d cycles", cycles);
    $display("test failed");
    $finish;
  end

  initial begin
    int total;
    rst = 1'b1;
    preif_raddr_i = '0;
    preif_raddr_valid_i = 1'b0;
    addr_lfsr = 16'd7;
    test_name = "reset";
    word_checks = 0;
    req_checks = 0;
    word_errors = 0;
    addr_errors = 0;
    len_errors = 0;
    other_errors = 0;
    for (int i = 0; i < icache_pkg::LINES; i++) begin
      model_valid[i] = 1'b0;
      model_tag[i] = '0;
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;
    // outputs must stay quiet with no request
    idle_cycles(5);
    test_name = "cold_fetch";
    fetch(32'h0000_2354);
    idle_cycles(2);
    // rest of the line, back to back
    test_name = "same_line";
    for (int w = 0; w < icache_pkg::BEATS; w++) begin
      if (w != 5) begin
        fetch(32'h0000_2340 + 4 * w);
      end
    end
    idle_cycles(2);
    test_name = "conflict";
    fetch(32'h0001_2348);
    fetch(32'h0000_2348);
    idle_cycles(2);
    test_name = "uncached";
    fetch(32'h1000_0124);
    fetch(32'h1000_0124);
    idle_cycles(2);
    test_name = "random";
    random_fetches(N_RAND);
    idle_cycles(4);
    if (fetch_q.size() != 0 || req_addr_q.size() != 0) begin
      other_errors++;
      $display("%0d fetches and %0d memory requests were never seen",
               fetch_q.size(), req_addr_q.size());
    end
    total = word_errors + addr_errors + len_errors + other_errors;
    $display("%0d word checks, %0d request checks, errors: %0d word %0d addr %0d len %0d other",
             word_checks, req_checks, word_errors, addr_errors, len_errors, other_errors);
    if (total == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/icache_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

// lookup / refill / uncached FSM
module icache_ctrl (
  input  wire                          clk,
  input  wire                          rst,
  // fetch side
  input  wire icache_pkg::addr_t       preif_raddr_i,
  input  wire                          preif_raddr_valid_i,
  output icache_pkg::word_t            if_rdata_o,
  output logic                         if_rdata_valid_o,
  // memory side
  output logic                         mem_req_o,
  output icache_pkg::addr_t            mem_addr_o,
  output icache_pkg::len_t             mem_len_o,
  input  wire                          mem_ack_i,
  input  wire icache_pkg::word_t       mem_data_i,
  // tag store
  output icache_pkg::index_t           rd_index_o,
  output icache_pkg::tag_t             lookup_tag_o,
  output icache_pkg::index_t           lookup_index_o,
  output logic                         tag_we_o,
  input  wire                          hit_i,
  // data RAM
  output icache_pkg::word_idx_t        data_addr_o,
  output logic                         data_we_o,
  output icache_pkg::word_t            data_wdata_o,
  input  wire icache_pkg::word_t       data_rdata_i
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_LOOKUP,
    ST_REFILL,
    ST_UNCACHED
  } state_t;

  state_t state_q;

  // captured request
  icache_pkg::addr_t req_addr_q;
  // beat number within the refill burst
  icache_pkg::beat_t beat_q;
  icache_pkg::word_t unc_word_q;
  // uncached word ready, high for one cycle
  logic unc_valid_q;

  // memory request registers
  logic mem_req_q;
  icache_pkg::addr_t mem_addr_q;
  icache_pkg::len_t mem_len_q;

  icache_pkg::index_t raw_index;
  icache_pkg::beat_t raw_word;
  icache_pkg::tag_t req_tag;
  icache_pkg::index_t req_index;
  logic req_uncached;
  logic beat_ack;
  logic last_beat;
  logic lookup_hit;
  logic capture;

  // fields of the incoming fetch address
  assign raw_index = preif_raddr_i[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign raw_word = preif_raddr_i[2 +: icache_pkg::BEAT_W];

  // fields of the captured address
  assign req_tag = req_addr_q[icache_pkg::ADDR_W-1 -: icache_pkg::TAG_W];
  assign req_index = req_addr_q[icache_pkg::OFFSET_W +: icache_pkg::INDEX_W];
  assign req_uncached = (req_addr_q[icache_pkg::ADDR_W-1 -: 4] == icache_pkg::UNCACHED_NIBBLE);

  // one beat per cycle with req and ack both high
  assign beat_ack = mem_req_q && mem_ack_i;
  assign last_beat = (beat_q == mem_len_q[icache_pkg::BEAT_W-1:0]);

  // uncached addresses never allocate, so never count as hits
  assign lookup_hit = (state_q == ST_LOOKUP) && hit_i && !req_uncached;
  // take a new request in idle, or right behind a hit
  assign capture = preif_raddr_valid_i && ((state_q == ST_IDLE) || lookup_hit);

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      mem_req_q <= 1'b0;
      beat_q <= '0;
      unc_valid_q <= 1'b0;
    end else begin
      unc_valid_q <= 1'b0;
      case (state_q)
        ST_IDLE: begin
          if (capture) begin
            state_q <= ST_LOOKUP;
          end
        end
        ST_LOOKUP: begin
          if (req_uncached) begin
            // single beat, no allocation
            mem_req_q <= 1'b1;
            state_q <= ST_UNCACHED;
          end else if (!hit_i) begin
            // miss, fetch the whole line
            mem_req_q <= 1'b1;
            beat_q <= '0;
            state_q <= ST_REFILL;
          end else if (!preif_raddr_valid_i) begin
            state_q <= ST_IDLE;
          end
        end
        ST_REFILL: begin
          if (beat_ack) begin
            if (last_beat) begin
              // tag written this cycle, idle re-captures the held address
              mem_req_q <= 1'b0;
              state_q <= ST_IDLE;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
        end
        ST_UNCACHED: begin
          if (beat_ack) begin
            mem_req_q <= 1'b0;
            unc_valid_q <= 1'b1;
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  // address, burst setup and uncached data
  always_ff @(posedge clk) begin
    if (capture) begin
      req_addr_q <= preif_raddr_i;
    end
    if ((state_q == ST_LOOKUP) && !lookup_hit) begin
      if (req_uncached) begin
        // exact word address
        mem_addr_q <= {req_addr_q[icache_pkg::ADDR_W-1:2], 2'b00};
        mem_len_q <= '0;
      end else begin
        // line base address
        mem_addr_q <= {req_tag, req_index, {icache_pkg::OFFSET_W{1'b0}}};
        mem_len_q <= icache_pkg::len_t'(icache_pkg::BEATS - 1);
      end
    end
    if ((state_q == ST_UNCACHED) && beat_ack) begin
      unc_word_q <= mem_data_i;
    end
  end

  assign mem_req_o = mem_req_q;
  assign mem_addr_o = mem_addr_q;
  assign mem_len_o = mem_len_q;

  // tag store reads the raw index, compares against the captured tag
  assign rd_index_o = raw_index;
  assign lookup_tag_o = req_tag;
  assign lookup_index_o = req_index;
  assign tag_we_o = (state_q == ST_REFILL) && beat_ack && last_beat;

  // refill writes {line, beat}; otherwise read at the raw word
  assign data_addr_o = (state_q == ST_REFILL) ? {req_index, beat_q} : {raw_index, raw_word};
  assign data_we_o = (state_q == ST_REFILL) && beat_ack;
  assign data_wdata_o = mem_data_i;

  // word select
  assign if_rdata_o = unc_valid_q ? unc_word_q : data_rdata_i;
  assign if_rdata_valid_o = lookup_hit || unc_valid_q;

  // memory sees a fixed address and length for the whole burst
  a_req_stable: assert property (@(posedge clk) disable iff (rst)
    mem_req_o && $past(mem_req_o) |-> $stable(mem_addr_o) && $stable(mem_len_o));

  // no word reaches fetch while a line is being filled
  a_no_valid_in_refill: assert property (@(posedge clk) disable iff (rst)
    (state_q == ST_REFILL) |-> !if_rdata_valid_o);

endmodule

`default_nettype wire

//--- src/icache_pkg.sv
`default_nettype none

package icache_pkg;

  // fetch address and instruction word widths
  localparam int ADDR_W = 32;
  localparam int WORD_W = 32;

  // address split: tag | index | byte offset
  localparam int OFFSET_W = 6;
  localparam int INDEX_W = 7;
  localparam int TAG_W = ADDR_W - INDEX_W - OFFSET_W;

  // 128 lines of 64 bytes, 8 KB total
  localparam int LINES = 1 << INDEX_W;
  // words per line, one memory beat each
  localparam int BEATS = 16;
  localparam int BEAT_W = 4;
  localparam int DATA_DEPTH = LINES * BEATS;

  // top nibble of the region that bypasses the cache
  localparam logic [3:0] UNCACHED_NIBBLE = 4'h1;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [WORD_W-1:0] word_t;
  typedef logic [TAG_W-1:0] tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [BEAT_W-1:0] beat_t;
  // data RAM address is {index, beat}
  typedef logic [INDEX_W+BEAT_W-1:0] word_idx_t;
  // burst length minus one
  typedef logic [7:0] len_t;

endpackage

`default_nettype wire

//--- src/icache_tag_store.sv
`timescale 1ns/1ps
`default_nettype none

// valid bits, tag RAM and hit compare
module icache_tag_store (
  input  wire                     clk,
  input  wire                     rst,
  input  wire icache_pkg::index_t rd_index_i,
  input  wire icache_pkg::tag_t   lookup_tag_i,
  input  wire icache_pkg::index_t lookup_index_i,
  input  wire                     tag_we_i,
  output logic                    hit_o
);

  // one valid flop per line
  logic [icache_pkg::LINES-1:0] valid_q;
  // valid bit of the line being read, aligned with tag RAM output
  logic valid_rd_q;

  icache_pkg::index_t tag_addr;
  icache_pkg::tag_t tag_rdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      valid_rd_q <= 1'b0;
    end else begin
      // read before set, same as the RAM
      valid_rd_q <= valid_q[rd_index_i];
      if (tag_we_i) begin
        valid_q[lookup_index_i] <= 1'b1;
      end
    end
  end

  // write goes to the refilled line, otherwise read the raw index
  assign tag_addr = tag_we_i ? lookup_index_i : rd_index_i;

  line_ram #(
    .entry_t(icache_pkg::tag_t),
    .DEPTH  (icache_pkg::LINES)
  ) u_tag_ram (
    .clk    (clk),
    .we_i   (tag_we_i),
    .addr_i (tag_addr),
    .wdata_i(lookup_tag_i),
    .rdata_o(tag_rdata)
  );

  assign hit_o = valid_rd_q && (tag_rdata == lookup_tag_i);

  // the line being refilled missed, so it cannot hit while its tag lands
  a_no_hit_on_fill: assert property (@(posedge clk) disable iff (rst)
    tag_we_i |-> !hit_o);

endmodule

`default_nettype wire

//--- src/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

// direct-mapped instruction cache, 8 KB, 64 B lines
module icache_top (
  input  wire                    clk,
  input  wire                    rst,
  // fetch side
  input  wire icache_pkg::addr_t preif_raddr_i,
  input  wire                    preif_raddr_valid_i,
  output icache_pkg::word_t      if_rdata_o,
  output logic                   if_rdata_valid_o,
  // memory side
  output logic                   mem_req_o,
  output icache_pkg::addr_t      mem_addr_o,
  output icache_pkg::len_t       mem_len_o,
  input  wire                    mem_ack_i,
  input  wire icache_pkg::word_t mem_data_i
);

  // controller to tag store
  icache_pkg::index_t rd_index;
  icache_pkg::tag_t lookup_tag;
  icache_pkg::index_t lookup_index;
  logic tag_we;
  logic hit;

  // controller to data RAM
  icache_pkg::word_idx_t data_addr;
  logic data_we;
  icache_pkg::word_t data_wdata;
  icache_pkg::word_t data_rdata;

  icache_ctrl u_ctrl (
    .clk                (clk),
    .rst                (rst),
    .preif_raddr_i      (preif_raddr_i),
    .preif_raddr_valid_i(preif_raddr_valid_i),
    .if_rdata_o         (if_rdata_o),
    .if_rdata_valid_o   (if_rdata_valid_o),
    .mem_req_o          (mem_req_o),
    .mem_addr_o         (mem_addr_o),
    .mem_len_o          (mem_len_o),
    .mem_ack_i          (mem_ack_i),
    .mem_data_i         (mem_data_i),
    .rd_index_o         (rd_index),
    .lookup_tag_o       (lookup_tag),
    .lookup_index_o     (lookup_index),
    .tag_we_o           (tag_we),
    .hit_i              (hit),
    .data_addr_o        (data_addr),
    .data_we_o          (data_we),
    .data_wdata_o       (data_wdata),
    .data_rdata_i       (data_rdata)
  );

  icache_tag_store u_tag_store (
    .clk           (clk),
    .rst           (rst),
    .rd_index_i    (rd_index),
    .lookup_tag_i  (lookup_tag),
    .lookup_index_i(lookup_index),
    .tag_we_i      (tag_we),
    .hit_o         (hit)
  );

  // 2048 words, one per beat of every line
  line_ram #(
    .entry_t(icache_pkg::word_t),
    .DEPTH  (icache_pkg::DATA_DEPTH)
  ) u_data_ram (
    .clk    (clk),
    .we_i   (data_we),
    .addr_i (data_addr),
    .wdata_i(data_wdata),
    .rdata_o(data_rdata)
  );

endmodule

`default_nettype wire

//--- src/line_ram.sv
`timescale 1ns/1ps
`default_nettype none

// single-port synchronous RAM
// used for tag entries and for data words
module line_ram #(
  parameter type entry_t = logic [31:0],
  parameter int DEPTH = 128
) (
  input  wire                       clk,
  input  wire                       we_i,
  input  wire [$clog2(DEPTH)-1:0]   addr_i,
  input  wire entry_t               wdata_i,
  output entry_t                    rdata_o
);

  // storage array
  entry_t mem [DEPTH];

  // registered read port
  entry_t rdata_q;

  always_ff @(posedge clk) begin
    // old entry is read out when writing the same address
    rdata_q <= mem[addr_i];
    if (we_i) begin
      mem[addr_i] <= wdata_i;
    end
  end

  // data valid one cycle after addr_i
  assign rdata_o = rdata_q;

endmodule

`default_nettype wire
